// ==== rtl/l2_cache_macros.svh ====
// cache geometry, datapath widths and drain delay; include ahead of the package and every RTL file
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// organization
`define L2_WAYS 4
`define L2_SETS 8
`define L2_WORDS 4

// widths in bits
`define L2_WORD_W 32
`define L2_LINE_W 128
`define L2_ADDR_W 32

// what remains above set, word and byte fields
`define L2_TAG_W 25

// idle cycles a full eviction buffer waits before writing back
`define L2_DRAIN_DELAY 15

`endif

// ==== rtl/l2_cache_pkg.sv ====
// address views and small index types of the l2 cache; modules import it where the body needs it
`include "l2_cache_macros.svh"

package l2_cache_pkg;

    // field widths derived from the geometry
    localparam int SET_W = $clog2(`L2_SETS);
    localparam int WORD_IDX_W = $clog2(`L2_WORDS);
    localparam int BYTE_W = $clog2(`L2_WORD_W / 8);
    localparam int OFFSET_W = WORD_IDX_W + BYTE_W;
    localparam int LINE_ADDR_W = `L2_ADDR_W - OFFSET_W;

    // lookup split: tag, set, word in line, byte in word
    typedef struct packed {
        logic [`L2_TAG_W-1:0] tag;
        logic [SET_W-1:0] set;
        logic [WORD_IDX_W-1:0] word;
        logic [BYTE_W-1:0] byte_off;
    } addr_lookup_t;

    // line split for memory and buffer addressing
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
        logic [OFFSET_W-1:0] offset;
    } addr_line_t;

    // same byte address, two decodes
    typedef union packed {
        addr_lookup_t lookup;
        addr_line_t line;
    } l2_addr_u;

    typedef logic [$clog2(`L2_WAYS)-1:0] way_idx_t;

    // one set's tree, bits {b2, b1, b0}
    typedef logic [2:0] plru_t;

endpackage

// ==== rtl/l2_cache_control.sv ====
// cache FSM: sequences lookup, victim eviction, line fill and idle drain of the eviction buffer
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_cache_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   pmem_resp,
    input  logic                   hit,
    input  l2_cache_pkg::way_idx_t hit_way,
    input  logic [`L2_WAYS-1:0]    way_hit,
    input  logic [`L2_WAYS-1:0]    way_dirty,
    input  l2_cache_pkg::way_idx_t victim_way,
    input  logic                   ewb_full,
    input  logic                   ewb_hit,
    output logic                   mem_resp,
    output logic                   pmem_read,
    output logic                   pmem_write,
    output logic                   pmem_addr_sel,
    output l2_cache_pkg::way_idx_t sel_way,
    output logic                   tag_load,
    output logic                   dirty_set,
    output logic                   invalidate,
    output logic                   word_write,
    output logic                   line_fill,
    output logic                   plru_update,
    output logic                   ewb_load,
    output logic                   ewb_word_write,
    output logic                   ewb_clear
);

    localparam int CNT_W = $clog2(`L2_DRAIN_DELAY + 1);

    typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, DEQUEUE} state_t;

    state_t state;
    state_t next_state;
    logic [CNT_W-1:0] drain_cnt;
    logic request;

    assign request = mem_read | mem_write;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // drain countdown, only runs while idle with a line parked
    always_ff @(posedge clk)
    begin
        if (rst)
            drain_cnt <= CNT_W'(`L2_DRAIN_DELAY);
        else if (state == IDLE && !request && ewb_full)
        begin
            if (drain_cnt != '0)
                drain_cnt <= drain_cnt - 1'b1;
        end
        else
            drain_cnt <= CNT_W'(`L2_DRAIN_DELAY);
    end

    always_comb
    begin
        next_state = state;
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        pmem_addr_sel = 1'b0;
        // victim way unless a lookup hits
        sel_way = victim_way;
        tag_load = 1'b0;
        dirty_set = 1'b0;
        invalidate = 1'b0;
        word_write = 1'b0;
        line_fill = 1'b0;
        plru_update = 1'b0;
        ewb_load = 1'b0;
        ewb_word_write = 1'b0;
        ewb_clear = 1'b0;
        case (state)
            IDLE:
            begin
                if (request)
                    next_state = LOOKUP;
                else if (ewb_full && drain_cnt == '0)
                    next_state = DEQUEUE;
            end
            LOOKUP:
            begin
                if (ewb_hit)
                begin
                    // served from the parked line, arrays left alone
                    mem_resp = 1'b1;
                    ewb_word_write = mem_write;
                    next_state = IDLE;
                end
                else if (hit)
                begin
                    mem_resp = 1'b1;
                    sel_way = hit_way;
                    plru_update = 1'b1;
                    // store hits in place and marks the line dirty
                    word_write = mem_write;
                    dirty_set = mem_write;
                    next_state = IDLE;
                end
                else if (!way_dirty[victim_way])
                    next_state = FILL;
                // dirty victim but buffer occupied, empty it first
                else if (ewb_full)
                    next_state = DEQUEUE;
                else
                    next_state = EVICT;
            end
            EVICT:
            begin
                // park the dirty line, free the way
                ewb_load = 1'b1;
                invalidate = 1'b1;
                next_state = FILL;
            end
            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    line_fill = 1'b1;
                    tag_load = 1'b1;
                    next_state = LOOKUP;
                end
            end
            DEQUEUE:
            begin
                pmem_write = 1'b1;
                pmem_addr_sel = 1'b1;
                if (pmem_resp)
                begin
                    ewb_clear = 1'b1;
                    next_state = request ? LOOKUP : IDLE;
                end
            end
            default:
                next_state = IDLE;
        endcase
    end

    // one line transfer at a time on the memory side
    assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

    // the CPU is answered from a lookup only
    assert property (@(posedge clk) disable iff (rst) mem_resp |-> state == LOOKUP);

    // a line being filled is not present in any way yet
    assert property (@(posedge clk) disable iff (rst)
        (state == FILL) |-> (way_hit == '0));

endmodule

// ==== rtl/l2_tag_store.sv ====
// tag, valid and dirty arrays per way with parallel tag compare on the addressed set
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_tag_store (
    input  logic                   clk,
    input  logic                   rst,
    input  l2_cache_pkg::l2_addr_u mem_address,
    input  l2_cache_pkg::way_idx_t sel_way,
    input  logic                   tag_load,
    input  logic                   dirty_set,
    input  logic                   invalidate,
    output logic [`L2_WAYS-1:0]    way_hit,
    output logic                   hit,
    output l2_cache_pkg::way_idx_t hit_way,
    output logic [`L2_WAYS-1:0]    way_valid,
    output logic [`L2_WAYS-1:0]    way_dirty,
    output logic [`L2_TAG_W-1:0]   victim_tag
);

    import l2_cache_pkg::*;

    logic [`L2_TAG_W-1:0] tags [`L2_WAYS][`L2_SETS];
    logic [`L2_SETS-1:0] valid [`L2_WAYS];
    logic [`L2_SETS-1:0] dirty [`L2_WAYS];
    logic [SET_W-1:0] set_idx;

    assign set_idx = mem_address.lookup.set;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
        end
        else if (tag_load)
        begin
            // freshly filled line is clean
            valid[sel_way][set_idx] <= 1'b1;
            dirty[sel_way][set_idx] <= 1'b0;
        end
        else if (invalidate)
        begin
            valid[sel_way][set_idx] <= 1'b0;
            dirty[sel_way][set_idx] <= 1'b0;
        end
        else if (dirty_set)
            dirty[sel_way][set_idx] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (tag_load)
            tags[sel_way][set_idx] <= mem_address.lookup.tag;
    end

    // compare all four ways at once
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            way_valid[w] = valid[w][set_idx];
            way_dirty[w] = dirty[w][set_idx];
            way_hit[w] = way_valid[w] && (tags[w][set_idx] == mem_address.lookup.tag);
            if (way_hit[w])
                hit_way = way_idx_t'(w);
        end
    end

    assign hit = |way_hit;

    // tag of the way being evicted, rebuilds its line address
    assign victim_tag = tags[sel_way][set_idx];

    // a line lives in one way only
    assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

// ==== rtl/l2_data_store.sv ====
// line data arrays: whole-line fill, single-word store merge and word select for reads
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_data_store (
    input  logic                   clk,
    input  l2_cache_pkg::l2_addr_u mem_address,
    input  logic [`L2_WORD_W-1:0]  mem_wdata,
    input  logic [`L2_LINE_W-1:0]  pmem_rdata,
    input  l2_cache_pkg::way_idx_t sel_way,
    input  logic                   word_write,
    input  logic                   line_fill,
    output logic [`L2_LINE_W-1:0]  mem_rdata_line,
    output logic [`L2_WORD_W-1:0]  mem_rdata
);

    import l2_cache_pkg::*;

    logic [`L2_LINE_W-1:0] lines [`L2_WAYS][`L2_SETS];
    logic [SET_W-1:0] set_idx;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [`L2_WORDS-1:0] word_strb;
    logic [`L2_LINE_W-1:0] write_line;

    assign set_idx = mem_address.lookup.set;
    assign word_idx = mem_address.lookup.word;

    // per-word strobes, fill hits all words, store only its own
    always_comb
    begin
        for (int i = 0; i < `L2_WORDS; i++)
        begin
            word_strb[i] = line_fill || (word_write && word_idx == WORD_IDX_W'(i));
            write_line[i*`L2_WORD_W +: `L2_WORD_W] =
                line_fill ? pmem_rdata[i*`L2_WORD_W +: `L2_WORD_W] : mem_wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `L2_WORDS; i++)
        begin
            if (word_strb[i])
                lines[sel_way][set_idx][i*`L2_WORD_W +: `L2_WORD_W] <=
                    write_line[i*`L2_WORD_W +: `L2_WORD_W];
        end
    end

    // whole line also feeds the eviction buffer
    assign mem_rdata_line = lines[sel_way][set_idx];
    assign mem_rdata = mem_rdata_line[word_idx*`L2_WORD_W +: `L2_WORD_W];

endmodule

// ==== rtl/l2_plru.sv ====
// tree pseudo-LRU per set: updates on hits, picks the victim way with invalid ways first
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_plru (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [l2_cache_pkg::SET_W-1:0] set_idx,
    input  logic                           plru_update,
    input  l2_cache_pkg::way_idx_t         hit_way,
    input  logic [`L2_WAYS-1:0]            way_valid,
    output l2_cache_pkg::way_idx_t         victim_way
);

    import l2_cache_pkg::*;

    plru_t tree [`L2_SETS];
    plru_t cur;
    plru_t upd;

    assign cur = tree[set_idx];

    // b2 records the half, b1 or b0 the way within it
    always_comb
    begin
        upd = cur;
        upd[2] = hit_way[1];
        if (hit_way[1])
            upd[0] = hit_way[0];
        else
            upd[1] = hit_way[0];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `L2_SETS; s++)
                tree[s] <= '0;
        end
        else if (plru_update)
            tree[set_idx] <= upd;
    end

    always_comb
    begin
        // walk away from the recent side
        if (cur[2] == 1'b0)
            victim_way = cur[0] ? way_idx_t'(2) : way_idx_t'(3);
        else
            victim_way = cur[1] ? way_idx_t'(0) : way_idx_t'(1);
        // empty way overrides, lowest index wins
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (!way_valid[w])
                victim_way = way_idx_t'(w);
        end
    end

endmodule

// ==== rtl/l2_evict_buffer.sv ====
// one-entry buffer for a dirty victim line: address match, word forward and store merge
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_evict_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  l2_cache_pkg::l2_addr_u mem_address,
    input  logic [`L2_WORD_W-1:0]  mem_wdata,
    input  logic [`L2_LINE_W-1:0]  victim_line,
    input  l2_cache_pkg::l2_addr_u victim_addr,
    input  logic                   ewb_load,
    input  logic                   ewb_word_write,
    input  logic                   ewb_clear,
    output logic                   ewb_full,
    output logic                   ewb_hit,
    output logic [`L2_WORD_W-1:0]  ewb_rdata,
    output logic [`L2_LINE_W-1:0]  ewb_line,
    output l2_cache_pkg::l2_addr_u ewb_addr
);

    import l2_cache_pkg::*;

    logic [LINE_ADDR_W-1:0] line_addr;
    logic [WORD_IDX_W-1:0] word_idx;

    // word number from the upper offset bits
    assign word_idx = mem_address.line.offset[OFFSET_W-1:BYTE_W];

    always_ff @(posedge clk)
    begin
        if (rst)
            ewb_full <= 1'b0;
        else if (ewb_load)
            ewb_full <= 1'b1;
        else if (ewb_clear)
            ewb_full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (ewb_load)
        begin
            ewb_line <= victim_line;
            line_addr <= victim_addr.line.line_addr;
        end
        // store to a parked line lands here, line stays dirty
        else if (ewb_word_write)
            ewb_line[word_idx*`L2_WORD_W +: `L2_WORD_W] <= mem_wdata;
    end

    assign ewb_hit = ewb_full && (line_addr == mem_address.line.line_addr);
    assign ewb_rdata = ewb_line[word_idx*`L2_WORD_W +: `L2_WORD_W];

    // drain address, line aligned
    assign ewb_addr = {line_addr, {OFFSET_W{1'b0}}};

    // FSM must drain before parking another victim
    assert property (@(posedge clk) disable iff (rst) ewb_load |-> !ewb_full);

endmodule

// ==== rtl/l2_cache.sv ====
// l2 cache top: joins the FSM, tag and data arrays, PLRU and eviction buffer to CPU and memory
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [`L2_ADDR_W-1:0] mem_address,
    input  logic [`L2_WORD_W-1:0] mem_wdata,
    output logic [`L2_WORD_W-1:0] mem_rdata,
    output logic                  mem_resp,
    output logic                  pmem_read,
    output logic                  pmem_write,
    output logic [`L2_ADDR_W-1:0] pmem_address,
    output logic [`L2_LINE_W-1:0] pmem_wdata,
    input  logic [`L2_LINE_W-1:0] pmem_rdata,
    input  logic                  pmem_resp
);

    import l2_cache_pkg::*;

    l2_addr_u req_addr;
    l2_addr_u victim_addr;
    l2_addr_u ewb_addr;
    way_idx_t hit_way;
    way_idx_t victim_way;
    way_idx_t sel_way;
    logic [`L2_WAYS-1:0] way_hit;
    logic [`L2_WAYS-1:0] way_valid;
    logic [`L2_WAYS-1:0] way_dirty;
    logic [`L2_TAG_W-1:0] victim_tag;
    logic hit;
    logic tag_load, dirty_set, invalidate;
    logic word_write, line_fill, plru_update;
    logic ewb_full, ewb_hit, ewb_load, ewb_word_write, ewb_clear;
    logic pmem_addr_sel;
    logic [`L2_LINE_W-1:0] cache_line;
    logic [`L2_WORD_W-1:0] cache_rdata;
    logic [`L2_WORD_W-1:0] ewb_rdata;

    assign req_addr = mem_address;

    // evicted line's address from its stored tag and the current set
    assign victim_addr = {victim_tag, req_addr.lookup.set, {OFFSET_W{1'b0}}};

    // buffer wins when it holds the line
    assign mem_rdata = ewb_hit ? ewb_rdata : cache_rdata;

    // drain uses the buffer address, fill the request line
    assign pmem_address = pmem_addr_sel ? ewb_addr
                                        : {req_addr.line.line_addr, {OFFSET_W{1'b0}}};

    l2_cache_control control (.*);

    l2_tag_store tag_store (.mem_address(req_addr), .*);

    l2_data_store data_store (
        .mem_address(req_addr),
        .mem_rdata_line(cache_line),
        .mem_rdata(cache_rdata),
        .*
    );

    l2_plru plru (.set_idx(req_addr.lookup.set), .*);

    l2_evict_buffer evict_buffer (
        .mem_address(req_addr),
        .victim_line(cache_line),
        .ewb_line(pmem_wdata),
        .*
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// testbench clock and reset source: 10 ns clock, reset held for three cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== sim/l2_cache_checker.sv ====
// monitor for the l2 cache: shadow word memory, read and write-back compares, error counts
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_cache_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  mem_read,
    input logic                  mem_write,
    input logic [`L2_ADDR_W-1:0] mem_address,
    input logic [`L2_WORD_W-1:0] mem_wdata,
    input logic [`L2_WORD_W-1:0] mem_rdata,
    input logic                  mem_resp,
    input logic                  pmem_write,
    input logic [`L2_ADDR_W-1:0] pmem_address,
    input logic [`L2_LINE_W-1:0] pmem_wdata,
    input logic                  pmem_resp
);

    int value_errors = 0;
    int other_errors = 0;
    string test_name = "reset";

    // last value written per word address
    logic [31:0] shadow [logic [29:0]];

    // power-up content of backing memory, odd multiplier keeps every address distinct
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // reference model: newest store wins, else the initial pattern
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2]))
            return shadow[addr[31:2]];
        return initial_word({addr[31:2], 2'b00});
    endfunction

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act)
        begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    // sampled on the rising edge, inputs settle at the falling edge before
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (mem_resp && mem_read)
                check_value("read data", expected_word(mem_address), mem_rdata);
            if (mem_resp && mem_write)
                shadow[mem_address[31:2]] = mem_wdata;
            if (pmem_write && pmem_resp)
            begin
                if (pmem_address[3:0] != 4'h0)
                begin
                    $display("%s: write-back address %h is not line aligned",
                             test_name, pmem_address);
                    other_errors++;
                end
                // each word of the line against the shadow
                for (int i = 0; i < `L2_WORDS; i++)
                    check_value("write-back word", expected_word(pmem_address + 32'(i * 4)),
                                pmem_wdata[i*`L2_WORD_W +: `L2_WORD_W]);
            end
        end
    end

endmodule

// ==== sim/l2_cache_tb.sv ====
// l2 cache testbench: CPU request sequences, backing memory with random latency, test flow
`timescale 1ns/1ps
`include "l2_cache_macros.svh"

module l2_cache_tb;

    // about 34 requests plus the drain idle time
    localparam int REQ_COUNT = 36;
    localparam int IDLE_CYCLES = `L2_DRAIN_DELAY + 40;
    localparam int CYCLE_LIMIT = 40 * REQ_COUNT + IDLE_CYCLES;

    logic clk;
    logic rst;
    logic mem_read;
    logic mem_write;
    logic [`L2_ADDR_W-1:0] mem_address;
    logic [`L2_WORD_W-1:0] mem_wdata;
    logic [`L2_WORD_W-1:0] mem_rdata;
    logic mem_resp;
    logic pmem_read;
    logic pmem_write;
    logic [`L2_ADDR_W-1:0] pmem_address;
    logic [`L2_LINE_W-1:0] pmem_wdata;
    logic [`L2_LINE_W-1:0] pmem_rdata;
    logic pmem_resp;
    logic [31:0] backing [logic [29:0]];
    int lat_left = 0;
    int pmem_reads = 0;
    int pmem_writes = 0;
    int cycles = 0;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));

    l2_cache DUT (.*);

    l2_cache_checker chk (.*);

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return {25'(tag), 3'(set), 2'(word), 2'b00};
    endfunction

    // same power-up pattern the checker assumes
    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        if (backing.exists(addr[31:2]))
            return backing[addr[31:2]];
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    // tree pseudo-LRU mirror for victim prediction
    function automatic logic [2:0] plru_touch(input logic [2:0] t, input int way);
        logic [2:0] n;
        n = t;
        case (way)
            0: n[2:1] = 2'b00;
            1: n[2:1] = 2'b01;
            2: {n[2], n[0]} = 2'b10;
            default: {n[2], n[0]} = 2'b11;
        endcase
        return n;
    endfunction

    function automatic int plru_victim(input logic [2:0] t);
        if (!t[2])
            return t[0] ? 2 : 3;
        return t[1] ? 0 : 1;
    endfunction

    // backing memory, answers after 1 to 4 falling edges
    always @(negedge clk)
    begin
        if (rst || pmem_resp)
            pmem_resp = 1'b0;
        else if (pmem_read || pmem_write)
        begin
            if (lat_left == 0)
                lat_left = $urandom_range(4, 1);
            lat_left--;
            if (lat_left == 0)
            begin
                for (int i = 0; i < `L2_WORDS; i++)
                begin
                    if (pmem_read)
                        pmem_rdata[i*32 +: 32] = memory_word({pmem_address[31:4], 2'(i), 2'b00});
                    else
                        backing[{pmem_address[31:4], 2'(i)}] = pmem_wdata[i*32 +: 32];
                end
                pmem_resp = 1'b1;
            end
        end
    end

    // completed line transfers
    always @(posedge clk)
    begin
        if (pmem_resp && pmem_read)
            pmem_reads++;
        if (pmem_resp && pmem_write)
            pmem_writes++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // one CPU request, held until mem_resp, ends on a falling edge
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          output int lat, output int rd_n, output int wr_n);
        int rd0;
        int wr0;
        rd0 = pmem_reads;
        wr0 = pmem_writes;
        mem_address = addr;
        mem_wdata = data;
        mem_read = !wr;
        mem_write = wr;
        lat = 0;
        do
        begin
            @(negedge clk);
            lat++;
        end
        while (!mem_resp);
        @(posedge clk);
        @(negedge clk);
        rd_n = pmem_reads - rd0;
        wr_n = pmem_writes - wr0;
        mem_read = 1'b0;
        mem_write = 1'b0;
    endtask

    initial
    begin
        int lat;
        int rd_n;
        int wr_n;
        int victim;
        int wr0;
        int order [4];
        logic [2:0] tree;
        void'($urandom(9));
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        pmem_rdata = '0;
        pmem_resp = 1'b0;
        order = '{2, 0, 3, 1};
        @(negedge rst);
        @(negedge clk);

        chk.set_test("reset_reads");
        chk.check_value("mem_resp after reset", 32'h0, 32'(mem_resp));
        chk.check_value("pmem_read after reset", 32'h0, 32'(pmem_read));
        chk.check_value("pmem_write after reset", 32'h0, 32'(pmem_write));
        for (int i = 0; i < 4; i++)
            access(1'b0, make_addr(10 + i, 4, i), '0, lat, rd_n, wr_n);

        chk.set_test("write_read");
        access(1'b1, make_addr(200, 2, 3), $urandom, lat, rd_n, wr_n);
        access(1'b0, make_addr(200, 2, 3), '0, lat, rd_n, wr_n);
        access(1'b0, make_addr(200, 2, 3), '0, lat, rd_n, wr_n);
        chk.check_value("hit latency", 32'd1, 32'(lat));
        chk.check_value("pmem reads on hit", 32'd0, 32'(rd_n));

        // fills land in ways 0..3 while invalid ways remain
        chk.set_test("plru_victim");
        tree = 3'b000;
        for (int i = 0; i < 4; i++)
        begin
            access(1'b0, make_addr(100 + i, 0, 1), '0, lat, rd_n, wr_n);
            tree = plru_touch(tree, i);
        end
        for (int i = 0; i < 4; i++)
        begin
            access(1'b0, make_addr(100 + order[i], 0, 0), '0, lat, rd_n, wr_n);
            tree = plru_touch(tree, order[i]);
        end
        victim = plru_victim(tree);
        access(1'b0, make_addr(104, 0, 0), '0, lat, rd_n, wr_n);
        for (int i = 0; i < 4; i++)
        begin
            if (i != victim)
            begin
                access(1'b0, make_addr(100 + i, 0, 2), '0, lat, rd_n, wr_n);
                chk.check_value("pmem reads for survivor", 32'd0, 32'(rd_n));
            end
        end
        access(1'b0, make_addr(100 + victim, 0, 2), '0, lat, rd_n, wr_n);
        chk.check_value("pmem reads for victim", 32'd1, 32'(rd_n));

        // dirty way0 is the victim of the fifth tag
        chk.set_test("evict_forward");
        access(1'b1, make_addr(300, 1, 1), $urandom, lat, rd_n, wr_n);
        for (int i = 1; i < 5; i++)
            access(1'b0, make_addr(300 + i, 1, 0), '0, lat, rd_n, wr_n);
        access(1'b0, make_addr(300, 1, 1), '0, lat, rd_n, wr_n);
        chk.check_value("pmem reads on buffer hit", 32'd0, 32'(rd_n));
        chk.check_value("pmem writes on buffer hit", 32'd0, 32'(wr_n));

        chk.set_test("drain");
        wr0 = pmem_writes;
        repeat (`L2_DRAIN_DELAY + 20) @(negedge clk);
        chk.check_value("drain writes", 32'd1, 32'(pmem_writes - wr0));

        // second dirty eviction while the buffer still holds the first
        chk.set_test("buffer_full");
        for (int i = 0; i < 4; i++)
            access(1'b1, make_addr(400 + i, 3, 0), $urandom, lat, rd_n, wr_n);
        access(1'b0, make_addr(404, 3, 0), '0, lat, rd_n, wr_n);
        access(1'b0, make_addr(405, 3, 0), '0, lat, rd_n, wr_n);
        chk.check_value("writes before full-buffer fill", 32'd1, 32'(wr_n));
        access(1'b0, make_addr(400, 3, 0), '0, lat, rd_n, wr_n);
        access(1'b0, make_addr(402, 3, 0), '0, lat, rd_n, wr_n);

        $display("errors: %0d value, %0d other", chk.value_errors, chk.other_errors);
        if (chk.value_errors + chk.other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/l2_cache_pkg.sv
rtl/l2_cache_control.sv
rtl/l2_tag_store.sv
rtl/l2_data_store.sv
rtl/l2_plru.sv
rtl/l2_evict_buffer.sv
rtl/l2_cache.sv
sim/tb_clock_gen.sv
sim/l2_cache_checker.sv
sim/l2_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the l2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module l2_cache_tb \
    -f project.f \
    -o sim_l2_cache

./obj_dir/sim_l2_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    exit 1
fi
exit 0
